// ==== include/core_defs.svh ====
// core sizing; memories are byte addressed, word accessed, and must be powers of two in size
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// 1 KiB of instruction memory
`define IMEM_ADDR_WIDTH 10

// 1 KiB of data memory
`define DMEM_ADDR_WIDTH 10

`define RESET_PC 32'h0000_0000

`define REG_COUNT 32

`endif

// ==== src/config_pkg.sv ====
// data-path widths; memory address types follow the widths in core_defs.svh
`include "core_defs.svh"

package config_pkg;

  // data, address and instruction value
  typedef logic [31:0] word;

  // register index
  typedef logic [4:0] r;

  // byte addresses into the two memories
  typedef logic [`IMEM_ADDR_WIDTH-1:0] imem_addr_t;
  typedef logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

endpackage

// ==== src/decoder_pkg.sv ====
// decoder control encodings; alu and branch ops follow the RV32I funct3 values
package decoder_pkg;

  // sub_arith turns add into sub and logical right shift into arithmetic
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SR   = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_op_t;

  typedef enum logic [1:0] {A_RS1, A_IMM, A_ZERO} alu_a_mux_t;

  typedef enum logic [1:0] {B_RS2, B_IMM, B_PC_PLUS_4, B_PC} alu_b_mux_t;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_op_t;

  typedef enum logic {PC_NEXT, PC_BRANCH} pc_mux_t;

  typedef enum logic {WB_ALU, WB_DM} wb_mux_t;

endpackage

// ==== src/decoder.sv ====
// RV32I decoder; only LW/SW widths, no CSR, FENCE or system ops, which decode as no-ops
`timescale 1ns/1ps

module decoder
  import config_pkg::*, decoder_pkg::*;
(
  input  word        instr,
  output r           rs1,
  output r           rs2,
  output r           rd,
  output word        imm,
  output alu_a_mux_t alu_a_mux_sel,
  output alu_b_mux_t alu_b_mux_sel,
  output alu_op_t    alu_op,
  output logic       sub_arith,
  output logic       branch_instr,
  output logic       jump_instr,
  output branch_op_t branch_op,
  output logic       dmem_write_enable,
  output wb_mux_t    wb_mux_sel,
  output logic       wb_write_enable
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // register fields sit at fixed positions in every format
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign branch_op = branch_op_t'(funct3);

  always_comb begin
    imm               = '0;
    alu_a_mux_sel     = A_RS1;
    alu_b_mux_sel     = B_IMM;
    alu_op            = ALU_ADD;
    sub_arith         = 1'b0;
    branch_instr      = 1'b0;
    jump_instr        = 1'b0;
    dmem_write_enable = 1'b0;
    wb_mux_sel        = WB_ALU;
    wb_write_enable   = 1'b1 & 1'b0;

    case (opcode)
      // lui adds imm to zero
      7'b0110111: begin
        imm             = imm_u;
        alu_a_mux_sel   = A_ZERO;
        wb_write_enable = 1'b1;
      end
      // auipc adds imm to pc
      7'b0010111: begin
        imm             = imm_u;
        alu_a_mux_sel   = A_IMM;
        alu_b_mux_sel   = B_PC;
        wb_write_enable = 1'b1;
      end
      // jal target is pc relative
      7'b1101111: begin
        imm             = imm_j;
        alu_a_mux_sel   = A_IMM;
        alu_b_mux_sel   = B_PC;
        jump_instr      = 1'b1;
        wb_write_enable = 1'b1;
      end
      // jalr target is rs1 plus imm
      7'b1100111: begin
        imm             = imm_i;
        jump_instr      = 1'b1;
        wb_write_enable = 1'b1;
      end
      7'b1100011: begin
        imm           = imm_b;
        alu_a_mux_sel = A_IMM;
        alu_b_mux_sel = B_PC;
        branch_instr  = 1'b1;
      end
      // word loads only
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          imm             = imm_i;
          wb_mux_sel      = WB_DM;
          wb_write_enable = 1'b1;
        end
      end
      7'b0100011: begin
        if (funct3 == 3'b010) begin
          imm               = imm_s;
          dmem_write_enable = 1'b1;
        end
      end
      // funct7 bit 5 only matters for srai in op-imm
      7'b0010011: begin
        imm             = imm_i;
        alu_op          = alu_op_t'(funct3);
        sub_arith       = (funct3 == 3'b101) && funct7[5];
        wb_write_enable = 1'b1;
      end
      7'b0110011: begin
        alu_b_mux_sel   = B_RS2;
        alu_op          = alu_op_t'(funct3);
        sub_arith       = funct7[5];
        wb_write_enable = 1'b1;
      end
      default: begin
      end
    endcase

    // x0 writes never reach the write-back stage
    if (rd == 5'd0) begin
      wb_write_enable = 1'b0;
    end
  end

endmodule

// ==== src/alu.sv ====
// combinational RV32I ALU; shift amounts use only the low five bits of b
`timescale 1ns/1ps

module alu
  import config_pkg::*, decoder_pkg::*;
(
  input  word     a,
  input  word     b,
  input  alu_op_t op,
  input  logic    sub_arith,
  output word     res
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  res = sub_arith ? a - b : a + b;
      ALU_SLL:  res = a << shamt;
      ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: res = {31'b0, a < b};
      ALU_XOR:  res = a ^ b;
      // sra keeps the sign bit
      ALU_SR:   res = sub_arith ? word'($signed(a) >>> shamt) : a >> shamt;
      ALU_OR:   res = a | b;
      ALU_AND:  res = a & b;
      default:  res = '0;
    endcase
  end

endmodule

// ==== src/branch_logic.sv ====
// next-PC select; funct3 codes outside the six branches are never taken
`timescale 1ns/1ps

module branch_logic
  import config_pkg::*, decoder_pkg::*;
(
  input  word        a,
  input  word        b,
  input  logic       branch_instr,
  input  logic       jump_instr,
  input  branch_op_t op,
  output pc_mux_t    out
);

  logic taken;

  always_comb begin
    case (op)
      BR_BEQ:  taken = (a == b);
      BR_BNE:  taken = (a != b);
      BR_BLT:  taken = ($signed(a) < $signed(b));
      BR_BGE:  taken = ($signed(a) >= $signed(b));
      BR_BLTU: taken = (a < b);
      BR_BGEU: taken = (a >= b);
      default: taken = 1'b0;
    endcase
  end

  // jumps always redirect
  assign out = (jump_instr || (branch_instr && taken)) ? PC_BRANCH : PC_NEXT;

endmodule

// ==== src/register_file.sv ====
// 32 x 32 register file; x0 reads zero and a same-cycle write is bypassed to the reads
`timescale 1ns/1ps
`include "core_defs.svh"

module register_file
  import config_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic write_en,
  input  r     write_addr,
  input  word  write_data,
  input  r     read_addr1,
  input  r     read_addr2,
  output word  read_data1,
  output word  read_data2
);

  word regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  // bypass lets an instruction see its predecessor's result
  assign read_data1 = (read_addr1 == 5'd0) ? '0 :
                      (write_en && read_addr1 == write_addr) ? write_data : regs[read_addr1];
  assign read_data2 = (read_addr2 == 5'd0) ? '0 :
                      (write_en && read_addr2 == write_addr) ? write_data : regs[read_addr2];

endmodule

// ==== src/mem.sv ====
// word memory, no reset; misaligned accesses read zero, drop writes and raise the flag
`timescale 1ns/1ps

module mem
  import config_pkg::*;
#(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  write_enable,
  input  logic [ADDR_WIDTH-1:0] address,
  input  word                   data_in,
  output word                   data_out,
  output logic                  alignment_error
);

  localparam int depth = 2 ** (ADDR_WIDTH - 2);

  word storage [depth];
  logic [ADDR_WIDTH-3:0] word_index;

  assign word_index      = address[ADDR_WIDTH-1:2];
  assign alignment_error = (address[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (write_enable && !alignment_error) begin
      storage[word_index] <= data_in;
    end
  end

  // combinational read
  assign data_out = alignment_error ? '0 : storage[word_index];

endmodule

// ==== src/top.sv ====
// single-cycle RV32I core; no CSR, traps or sub-word memory ops, imem is loaded while rst is high
`timescale 1ns/1ps
`include "core_defs.svh"

module top
  import config_pkg::*, decoder_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       imem_load,
  input  imem_addr_t imem_load_addr,
  input  word        imem_load_data,
  output word        pc,
  output logic       wb_valid,
  output r           wb_rd,
  output word        wb_data,
  output logic       mem_misaligned
);

  word pc_plus_4;
  word branch_target;
  word next_pc;
  imem_addr_t imem_addr;
  word instr;
  logic imem_alignment_error;

  r rs1, rs2, rd;
  word imm;
  alu_a_mux_t alu_a_mux_sel;
  alu_b_mux_t alu_b_mux_sel;
  alu_op_t alu_op;
  logic sub_arith;
  logic branch_instr;
  logic jump_instr;
  branch_op_t branch_op;
  logic dmem_write_enable;
  wb_mux_t wb_mux_sel;
  logic wb_write_enable;

  word rs1_data, rs2_data;
  pc_mux_t pc_sel;
  word alu_a, alu_b, alu_res;
  dmem_addr_t dmem_addr;
  word dmem_data_out;
  logic dmem_alignment_error;
  word wb_mux_out;

  assign pc_plus_4 = pc + 32'd4;
  // jalr needs bit 0 cleared and other targets are already even
  assign branch_target = {alu_res[31:1], 1'b0};
  assign next_pc = (pc_sel == PC_BRANCH) ? branch_target : pc_plus_4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // load port shares the imem address during reset
  assign imem_addr = imem_load ? imem_load_addr : pc[`IMEM_ADDR_WIDTH-1:0];

  mem #(.ADDR_WIDTH(`IMEM_ADDR_WIDTH)) imem (
    .clk(clk),
    .write_enable(imem_load),
    .address(imem_addr),
    .data_in(imem_load_data),
    .data_out(instr),
    .alignment_error(imem_alignment_error)
  );

  decoder decoder (
    .instr(instr),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .imm(imm),
    .alu_a_mux_sel(alu_a_mux_sel),
    .alu_b_mux_sel(alu_b_mux_sel),
    .alu_op(alu_op),
    .sub_arith(sub_arith),
    .branch_instr(branch_instr),
    .jump_instr(jump_instr),
    .branch_op(branch_op),
    .dmem_write_enable(dmem_write_enable),
    .wb_mux_sel(wb_mux_sel),
    .wb_write_enable(wb_write_enable)
  );

  // written back one cycle after execute
  register_file rf (
    .clk(clk),
    .rst(rst),
    .write_en(wb_valid),
    .write_addr(wb_rd),
    .write_data(wb_data),
    .read_addr1(rs1),
    .read_addr2(rs2),
    .read_data1(rs1_data),
    .read_data2(rs2_data)
  );

  branch_logic branch_logic (
    .a(rs1_data),
    .b(rs2_data),
    .branch_instr(branch_instr),
    .jump_instr(jump_instr),
    .op(branch_op),
    .out(pc_sel)
  );

  always_comb begin
    case (alu_a_mux_sel)
      A_RS1:   alu_a = rs1_data;
      A_IMM:   alu_a = imm;
      default: alu_a = '0;
    endcase
  end

  always_comb begin
    case (alu_b_mux_sel)
      B_RS2:       alu_b = rs2_data;
      B_IMM:       alu_b = imm;
      B_PC_PLUS_4: alu_b = pc_plus_4;
      default:     alu_b = pc;
    endcase
  end

  alu alu (
    .a(alu_a),
    .b(alu_b),
    .op(alu_op),
    .sub_arith(sub_arith),
    .res(alu_res)
  );

  assign dmem_addr = alu_res[`DMEM_ADDR_WIDTH-1:0];

  mem #(.ADDR_WIDTH(`DMEM_ADDR_WIDTH)) dmem (
    .clk(clk),
    .write_enable(dmem_write_enable),
    .address(dmem_addr),
    .data_in(rs2_data),
    .data_out(dmem_data_out),
    .alignment_error(dmem_alignment_error)
  );

  // dmem flag only counts on an actual load or store
  assign mem_misaligned = imem_alignment_error |
                          (dmem_alignment_error & (dmem_write_enable | (wb_mux_sel == WB_DM)));

  // jumps write the link value and loads the dmem word
  assign wb_mux_out = jump_instr ? pc_plus_4 :
                      (wb_mux_sel == WB_DM) ? dmem_data_out : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= wb_write_enable;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= rd;
    wb_data <= wb_mux_out;
  end

endmodule

// ==== test/top_assertions.sv ====
// checks on the core top outputs; expects rst high from the first clock edge
`timescale 1ns/1ps

module top_assertions
  import config_pkg::*;
(
  input logic clk,
  input logic rst,
  input word  pc,
  input logic wb_valid,
  input r     wb_rd
);

  int assert_failures = 0;

  // x0 results are dropped in decode
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != 5'd0)
    else begin
      $error("write-back to x0 with wb_valid set");
      assert_failures++;
    end

  pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc %08h is not word aligned", pc);
      assert_failures++;
    end

  // one edge with rst high clears the write-back valid
  wb_low_in_reset: assert property (@(posedge clk) rst |=> !wb_valid)
    else begin
      $error("wb_valid set during reset");
      assert_failures++;
    end

endmodule

bind top top_assertions checks (
  .clk(clk),
  .rst(rst),
  .pc(pc),
  .wb_valid(wb_valid),
  .wb_rd(wb_rd)
);

// ==== test/tb_top.sv ====
// run from the project root; the trace must fit in 256 words and the program in imem
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_top
  import config_pkg::*;
();

  localparam int trace_depth = 256;
  localparam int imem_words  = 2 ** (`IMEM_ADDR_WIDTH - 2);

  logic       clk;
  logic       rst;
  logic       imem_load;
  imem_addr_t imem_load_addr;
  word        imem_load_data;
  word        pc;
  logic       wb_valid;
  r           wb_rd;
  word        wb_data;
  logic       mem_misaligned;

  word trace_mem [trace_depth];

  int error_count;
  int check_count;
  int cycle_count;
  int timeout_cycles;
  int prog_words;
  int wb_expected;
  int wb_seen;

  top dut (
    .clk(clk),
    .rst(rst),
    .imem_load(imem_load),
    .imem_load_addr(imem_load_addr),
    .imem_load_data(imem_load_data),
    .pc(pc),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .mem_misaligned(mem_misaligned)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_word(input string name, input word expected, input word actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  task automatic check_reg(input string name, input r expected, input r actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // one word per clock through the imem load strobe
  task automatic load_program();
    for (int i = 0; i < prog_words; i++) begin
      @(posedge clk);
      #1;
      imem_load      = 1'b1;
      imem_load_addr = imem_addr_t'(i * 4);
      imem_load_data = trace_mem[8'(i + 1)];
    end
    @(posedge clk);
    #1;
    imem_load = 1'b0;
  endtask

  // expected pairs follow the write-back count
  task automatic compare_write_backs();
    int base;
    int idx;
    string name;
    base = prog_words + 2;
    while (wb_seen < wb_expected) begin
      @(posedge clk);
      #1;
      check_bit("mem_misaligned low", 1'b0, mem_misaligned);
      if (wb_valid) begin
        idx  = base + 2 * wb_seen;
        name = $sformatf("write-back %0d", wb_seen);
        check_reg(name, r'(trace_mem[idx[7:0]]), wb_rd);
        check_word(name, trace_mem[8'(idx + 1)], wb_data);
        wb_seen++;
      end
    end
  endtask

  initial begin
    wait (timeout_cycles > 0);
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles with %0d of %0d write-backs seen",
             cycle_count, wb_seen, wb_expected);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    imem_load      = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    error_count    = 0;
    check_count    = 0;
    timeout_cycles = 0;
    wb_expected    = 0;
    wb_seen        = 0;

    $readmemh("test/core_trace.txt", trace_mem);
    prog_words = int'(trace_mem[0]);
    if ($isunknown(trace_mem[0]) || prog_words < 1 || prog_words > imem_words) begin
      $display("trace file is missing or gives a bad program word count");
      error_count++;
    end else begin
      wb_expected = int'(trace_mem[8'(prog_words + 1)]);
      if (wb_expected < 1 || prog_words + 2 + 2 * wb_expected > trace_depth) begin
        $display("trace file gives a bad write-back count");
        error_count++;
      end else begin
        timeout_cycles = 20 * prog_words + 50;
        load_program();
        repeat (10) begin
          @(posedge clk);
        end
        #1;
        check_bit("wb_valid in reset", 1'b0, wb_valid);
        check_word("pc in reset", `RESET_PC, pc);
        rst = 1'b0;
        compare_write_backs();
      end
    end

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, dut.checks.assert_failures);
    if (error_count == 0 && dut.checks.assert_failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/config_pkg.sv
src/decoder_pkg.sv
src/decoder.sv
src/alu.sv
src/branch_logic.sv
src/register_file.sv
src/mem.sv
src/top.sv
test/top_assertions.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_top -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== test/core_trace.txt ====
// program word count, then one instruction word per line at pc 0, 4, 8 and so on
// then the write-back count, then one "rd data" pair per line in retire order
00000032
ff800093 // 00 addi x1, x0, -8
00300113 // 04 addi x2, x0, 3
002081b3 // 08 add x3, x1, x2
40110233 // 0c sub x4, x2, x1
4020d2b3 // 10 sra x5, x1, x2
0020d333 // 14 srl x6, x1, x2
0020a3b3 // 18 slt x7, x1, x2
0020b433 // 1c sltu x8, x1, x2
0f014493 // 20 xori x9, x2, 0xf0
7004e513 // 24 ori x10, x9, 0x700
0ff57593 // 28 andi x11, x10, 0xff
00411613 // 2c slli x12, x2, 4
4010d693 // 30 srai x13, x1, 1
01c0d713 // 34 srli x14, x1, 28
ff90a793 // 38 slti x15, x1, -7
fff13813 // 3c sltiu x16, x2, -1
002118b3 // 40 sll x17, x2, x2
0020c933 // 44 xor x18, x1, x2
004169b3 // 48 or x19, x2, x4
0040fa33 // 4c and x20, x1, x4
12345ab7 // 50 lui x21, 0x12345
00001b17 // 54 auipc x22, 0x1
01562823 // 58 sw x21, 16(x12)
01062b83 // 5c lw x23, 16(x12)
001b8c13 // 60 addi x24, x23, 1
00500013 // 64 addi x0, x0, 5
00208463 // 68 beq x1, x2, +8 not taken
00210463 // 6c beq x2, x2, +8 taken
00100f93 // 70 addi x31, x0, 1 skipped
00211463 // 74 bne x2, x2, +8 not taken
00209463 // 78 bne x1, x2, +8 taken
00200f93 // 7c addi x31, x0, 2 skipped
00114463 // 80 blt x2, x1, +8 not taken
0020c463 // 84 blt x1, x2, +8 taken
00300f93 // 88 addi x31, x0, 3 skipped
0020d463 // 8c bge x1, x2, +8 not taken
00115463 // 90 bge x2, x1, +8 taken
00400f93 // 94 addi x31, x0, 4 skipped
0020e463 // 98 bltu x1, x2, +8 not taken
00116463 // 9c bltu x2, x1, +8 taken
00500f93 // a0 addi x31, x0, 5 skipped
00117463 // a4 bgeu x2, x1, +8 not taken
0020f463 // a8 bgeu x1, x2, +8 taken
00600f93 // ac addi x31, x0, 6 skipped
00800d6f // b0 jal x26, +8
00700f93 // b4 addi x31, x0, 7 skipped
00dd0de7 // b8 jalr x27, 13(x26) lands on c0
00800f93 // bc addi x31, x0, 8 skipped
000d8e13 // c0 addi x28, x27, 0
0000006f // c4 jal x0, 0
0000001b
01 fffffff8
02 00000003
03 fffffffb
04 0000000b
05 ffffffff
06 1fffffff
07 00000001
08 00000000
09 000000f3
0a 000007f3
0b 000000f3
0c 00000030
0d fffffffc
0e 0000000f
0f 00000001
10 00000001
11 00000018
12 fffffffb
13 0000000b
14 00000008
15 12345000
16 00001054
17 12345000
18 12345001
1a 000000b4
1b 000000bc
1c 000000bc
